// ==== logic/qs_cfg_pkg.sv ====
// Sorter sizing package with word width, bank geometry and basic data types
package qs_cfg_pkg;

  // Width of one data word
  localparam int word_w = 16;

  // Words per bank, so also the longest packet
  localparam int entry_n = 16;

  // Banks in the round-robin rotation
  localparam int bank_n = 2;

  // Range entries held by the sorter stack
  localparam int stack_depth = entry_n;

  // One data word
  typedef logic [word_w-1:0] word_t;

  // Word address inside a bank
  typedef logic [$clog2(entry_n)-1:0] addr_t;

  // Bank number
  typedef logic [$clog2(bank_n)-1:0] bank_idx_t;

endpackage

// ==== logic/qs_ctrl_pkg.sv ====
// Control package with bank status, client request structs and FSM encodings
package qs_ctrl_pkg;

  // Life cycle of a bank
  // Loader owns idle and loading, sorter ready and sorting, emitter the rest
  typedef enum logic [2:0] {
    bank_idle,
    bank_loading,
    bank_ready,
    bank_sorting,
    bank_sorted,
    bank_unloading
  } bank_status_t;

  // Status plus address of the packet's final word
  typedef struct packed {
    bank_status_t      status;
    qs_cfg_pkg::addr_t last;
  } bank_state_t;

  // One client's status write, steered by bank number
  typedef struct packed {
    logic                  en;
    qs_cfg_pkg::bank_idx_t bank;
    bank_state_t           state;
  } bank_update_t;

  // One client's access to a bank memory
  typedef struct packed {
    logic                  en;
    logic                  wen;
    qs_cfg_pkg::bank_idx_t bank;
    qs_cfg_pkg::addr_t     addr;
    qs_cfg_pkg::word_t     din;
  } mem_req_t;

  typedef enum logic {ld_idle, ld_load} load_state_t;

  typedef enum logic {em_idle, em_emit} emit_state_t;

  // Quicksort FSM, each read state is followed by a cycle that sees the data
  typedef enum logic [3:0] {
    sort_idle,
    sort_pop,
    sort_rd_pivot,
    sort_rd_j,
    sort_cmp_j,
    sort_rd_i,
    sort_wr_i,
    sort_wr_j,
    sort_rd_hi,
    sort_fix_i,
    sort_fix_hi,
    sort_done
  } sort_state_t;

  // One pending range on the sort stack
  typedef struct packed {
    qs_cfg_pkg::addr_t lo;
    qs_cfg_pkg::addr_t hi;
  } sort_range_t;

endpackage

// ==== logic/packet_loader.sv ====
// Packet loader that writes incoming words into the current load bank
`timescale 1ns/10ps

module packet_loader (
  input  logic                                                clk,
  input  logic                                                rst,
  input  logic                                                unsorted_vld,
  input  logic                                                unsorted_eop,
  input  qs_cfg_pkg::word_t                                   unsorted_dat,
  input  qs_ctrl_pkg::bank_state_t [qs_cfg_pkg::bank_n-1:0]  bank_status,
  output logic                                                unsorted_rdy,
  output qs_ctrl_pkg::mem_req_t                               mem_req,
  output qs_ctrl_pkg::bank_update_t                           update
);
  import qs_cfg_pkg::*;
  import qs_ctrl_pkg::*;

  load_state_t state;
  bank_idx_t   ptr;
  addr_t       idx;
  logic        accept;

  // Ready only while the bank under the load pointer is free
  assign unsorted_rdy = (bank_status[ptr].status == bank_idle);

  // Words after the first one are taken regardless of ready
  assign accept = unsorted_vld && ((state == ld_load) || unsorted_rdy);

  // Each accepted word is written in the cycle it arrives
  assign mem_req.en   = accept;
  assign mem_req.wen  = accept;
  assign mem_req.bank = ptr;
  assign mem_req.addr = idx;
  assign mem_req.din  = unsorted_dat;

  // Status follows every word
  // eop hands the bank over to the sorter
  assign update.en           = accept;
  assign update.bank         = ptr;
  assign update.state.status = unsorted_eop ? bank_ready : bank_loading;
  assign update.state.last   = idx;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ld_idle;
      ptr   <= '0;
      idx   <= '0;
    end else if (accept) begin
      if (unsorted_eop) begin
        // Packet done, move on to the next bank
        state <= ld_idle;
        ptr   <= ptr + 1'b1;
        idx   <= '0;
      end else begin
        state <= ld_load;
        idx   <= idx + 1'b1;
      end
    end
  end

endmodule

// ==== logic/partition_engine.sv ====
// Quicksort engine that sorts one bank in place with a Lomuto partition
`timescale 1ns/10ps

module partition_engine (
  input  logic                                                clk,
  input  logic                                                rst,
  input  qs_ctrl_pkg::bank_state_t [qs_cfg_pkg::bank_n-1:0]  bank_status,
  input  qs_cfg_pkg::word_t [qs_cfg_pkg::bank_n-1:0]         rd_data,
  output qs_ctrl_pkg::mem_req_t                               mem_req,
  output qs_ctrl_pkg::bank_update_t                           update
);
  import qs_cfg_pkg::*;
  import qs_ctrl_pkg::*;

  typedef logic [$clog2(stack_depth)-1:0] sp_t;

  sort_state_t state;
  bank_idx_t   ptr;
  sort_range_t stack [stack_depth];
  sp_t         sp;
  sort_range_t rng;
  addr_t       i;
  addr_t       j;
  word_t       pivot;
  word_t       wi;
  word_t       wj;
  word_t       rd_word;
  bank_state_t cur;
  sort_range_t top;
  sort_range_t lo_range;
  sort_range_t hi_range;
  logic        scan_end;
  logic        push_lo;
  logic        push_hi;

  assign cur     = bank_status[ptr];
  assign rd_word = rd_data[ptr];
  assign top     = stack[sp - 1'b1];

  // Last j of the scan is hi - 1
  assign scan_end = (j == rng.hi - 1'b1);

  // Subranges either side of the pivot, kept only with two or more words
  assign lo_range = '{lo: rng.lo, hi: i - 1'b1};
  assign hi_range = '{lo: i + 1'b1, hi: rng.hi};
  assign push_lo  = (i - rng.lo) > addr_t'(1);
  assign push_hi  = (rng.hi - i) > addr_t'(1);

  always_comb begin
    mem_req      = '0;
    mem_req.bank = ptr;
    update       = '0;
    update.bank  = ptr;
    update.state = cur;
    case (state)
      sort_idle: begin
        update.en           = (cur.status == bank_ready);
        update.state.status = bank_sorting;
      end
      sort_rd_pivot: begin
        mem_req.en   = 1'b1;
        mem_req.addr = rng.hi;
      end
      sort_rd_j: begin
        mem_req.en   = 1'b1;
        mem_req.addr = j;
      end
      // Both fetch the word at i, the second for the final exchange with hi
      sort_rd_i, sort_rd_hi: begin
        mem_req.en   = 1'b1;
        mem_req.addr = i;
      end
      sort_wr_i: begin
        mem_req     = '{en: 1'b1, wen: 1'b1, bank: ptr, addr: i, din: wj};
      end
      sort_wr_j: begin
        mem_req     = '{en: 1'b1, wen: 1'b1, bank: ptr, addr: j, din: wi};
      end
      sort_fix_i: begin
        mem_req     = '{en: 1'b1, wen: 1'b1, bank: ptr, addr: i, din: pivot};
      end
      sort_fix_hi: begin
        mem_req     = '{en: 1'b1, wen: 1'b1, bank: ptr, addr: rng.hi, din: wi};
      end
      sort_done: begin
        update.en           = 1'b1;
        update.state.status = bank_sorted;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= sort_idle;
      ptr   <= '0;
      sp    <= '0;
    end else begin
      case (state)
        sort_idle: begin
          if (cur.status == bank_ready) begin
            // A single word is already sorted
            if (cur.last != '0) begin
              stack[0] <= '{lo: '0, hi: cur.last};
              sp       <= sp_t'(1);
            end
            state <= sort_pop;
          end
        end
        sort_pop: begin
          if (sp == '0) begin
            state <= sort_done;
          end else begin
            rng   <= top;
            i     <= top.lo;
            j     <= top.lo;
            sp    <= sp - 1'b1;
            state <= sort_rd_pivot;
          end
        end
        sort_rd_pivot: state <= sort_rd_j;
        sort_rd_j: begin
          // j sits at lo only on the first pass, while the pivot word is out
          if (j == rng.lo) begin
            pivot <= rd_word;
          end
          state <= sort_cmp_j;
        end
        sort_cmp_j: begin
          wj <= rd_word;
          if (rd_word < pivot) begin
            state <= sort_rd_i;
          end else if (scan_end) begin
            state <= sort_rd_hi;
          end else begin
            j     <= j + 1'b1;
            state <= sort_rd_j;
          end
        end
        sort_rd_i: state <= sort_wr_i;
        sort_wr_i: begin
          wi    <= rd_word;
          state <= sort_wr_j;
        end
        sort_wr_j: begin
          i <= i + 1'b1;
          if (scan_end) begin
            state <= sort_rd_hi;
          end else begin
            j     <= j + 1'b1;
            state <= sort_rd_j;
          end
        end
        sort_rd_hi: state <= sort_fix_i;
        sort_fix_i: begin
          wi    <= rd_word;
          state <= sort_fix_hi;
        end
        sort_fix_hi: begin
          // Up to two ranges go on the stack in one cycle
          if (push_lo) begin
            stack[sp] <= lo_range;
          end
          if (push_hi) begin
            stack[sp + sp_t'(push_lo)] <= hi_range;
          end
          sp    <= sp + sp_t'(push_lo) + sp_t'(push_hi);
          state <= sort_pop;
        end
        sort_done: begin
          ptr   <= ptr + 1'b1;
          state <= sort_idle;
        end
        default: state <= sort_idle;
      endcase
    end
  end

endmodule

// ==== logic/packet_emitter.sv ====
// Packet emitter that streams sorted banks out with start and end framing
`timescale 1ns/10ps

module packet_emitter (
  input  logic                                                clk,
  input  logic                                                rst,
  input  qs_ctrl_pkg::bank_state_t [qs_cfg_pkg::bank_n-1:0]  bank_status,
  input  qs_cfg_pkg::word_t [qs_cfg_pkg::bank_n-1:0]         rd_data,
  output qs_ctrl_pkg::mem_req_t                               mem_req,
  output qs_ctrl_pkg::bank_update_t                           update,
  output logic                                                sorted_vld,
  output logic                                                sorted_sop,
  output logic                                                sorted_eop,
  output qs_cfg_pkg::word_t                                   sorted_dat
);
  import qs_cfg_pkg::*;
  import qs_ctrl_pkg::*;

  // Framing that travels beside a read while the memory answers
  typedef struct packed {
    logic      vld;
    logic      sop;
    logic      eop;
    bank_idx_t bank;
  } side_t;

  emit_state_t state;
  bank_idx_t   ptr;
  addr_t       idx;
  bank_state_t cur;
  logic        rd_go;
  logic        rd_last;
  side_t       side_d;
  side_t       side_q;

  assign cur = bank_status[ptr];

  // Reading starts in the first cycle the bank shows sorted
  assign rd_go   = ((state == em_idle) && (cur.status == bank_sorted)) || (state == em_emit);
  assign rd_last = (idx == cur.last);

  // One read per cycle from address 0 up to last
  assign mem_req.en   = rd_go;
  assign mem_req.wen  = 1'b0;
  assign mem_req.bank = ptr;
  assign mem_req.addr = idx;
  assign mem_req.din  = '0;

  // Unloading on the first read, free again on the last
  assign update.en           = rd_go && ((state == em_idle) || rd_last);
  assign update.bank         = ptr;
  assign update.state.status = rd_last ? bank_idle : bank_unloading;
  assign update.state.last   = cur.last;

  assign side_d = '{vld: rd_go, sop: (state == em_idle), eop: rd_last, bank: ptr};

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= em_idle;
      ptr        <= '0;
      idx        <= '0;
      side_q     <= '0;
      sorted_vld <= 1'b0;
    end else begin
      side_q     <= side_d;
      sorted_vld <= side_q.vld;
      if (rd_go) begin
        if (rd_last) begin
          state <= em_idle;
          ptr   <= ptr + 1'b1;
          idx   <= '0;
        end else begin
          state <= em_emit;
          idx   <= idx + 1'b1;
        end
      end
    end
  end

  // Output register picks the word from the bank the read went to
  always_ff @(posedge clk) begin
    if (side_q.vld) begin
      sorted_sop <= side_q.sop;
      sorted_eop <= side_q.eop;
      sorted_dat <= rd_data[side_q.bank];
    end
  end

endmodule

// ==== logic/bank_store.sv ====
// Bank store with status registers, request steering and one memory per bank
`timescale 1ns/10ps

module bank_store (
  input  logic                                                clk,
  input  logic                                                rst,
  input  qs_ctrl_pkg::mem_req_t                               load_req,
  input  qs_ctrl_pkg::mem_req_t                               sort_req,
  input  qs_ctrl_pkg::mem_req_t                               emit_req,
  input  qs_ctrl_pkg::bank_update_t                           load_upd,
  input  qs_ctrl_pkg::bank_update_t                           sort_upd,
  input  qs_ctrl_pkg::bank_update_t                           emit_upd,
  output qs_ctrl_pkg::bank_state_t [qs_cfg_pkg::bank_n-1:0]  bank_status,
  output qs_cfg_pkg::word_t [qs_cfg_pkg::bank_n-1:0]         rd_data,
  output logic                                                busy
);
  import qs_cfg_pkg::*;
  import qs_ctrl_pkg::*;

  mem_req_t     [2:0]        reqs;
  bank_update_t [2:0]        upds;
  mem_req_t     [bank_n-1:0] bank_req;
  logic         [bank_n-1:0] upd_en;
  bank_state_t  [bank_n-1:0] upd_state;
  bank_state_t  [bank_n-1:0] status_q;
  logic                      any_busy;

  assign reqs = {emit_req, sort_req, load_req};
  assign upds = {emit_upd, sort_upd, load_upd};

  // Ownership by status keeps one client per bank
  // so the matching requests are simply ORed
  always_comb begin
    for (int b = 0; b < bank_n; b++) begin
      bank_req[b]  = '0;
      upd_en[b]    = 1'b0;
      upd_state[b] = '0;
      for (int c = 0; c < 3; c++) begin
        if (reqs[c].en && (reqs[c].bank == bank_idx_t'(b))) begin
          bank_req[b] = bank_req[b] | reqs[c];
        end
        if (upds[c].en && (upds[c].bank == bank_idx_t'(b))) begin
          upd_en[b]    = 1'b1;
          upd_state[b] = upd_state[b] | upds[c].state;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < bank_n; b++) begin
        status_q[b] <= '{status: bank_idle, last: '0};
      end
    end else begin
      for (int b = 0; b < bank_n; b++) begin
        if (upd_en[b]) begin
          status_q[b] <= upd_state[b];
        end
      end
    end
  end

  assign bank_status = status_q;

  // Busy while any bank holds a packet
  always_comb begin
    any_busy = 1'b0;
    for (int b = 0; b < bank_n; b++) begin
      any_busy = any_busy | (status_q[b].status != bank_idle);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else begin
      busy <= any_busy;
    end
  end

  // Single-port memories, read data registered and held between reads
  for (genvar b = 0; b < bank_n; b++) begin : g_bank
    word_t mem [entry_n];
    word_t rd_q;

    always_ff @(posedge clk) begin
      if (bank_req[b].en) begin
        if (bank_req[b].wen) begin
          mem[bank_req[b].addr] <= bank_req[b].din;
        end else begin
          rd_q <= mem[bank_req[b].addr];
        end
      end
    end

    assign rd_data[b] = rd_q;
  end

endmodule

// ==== logic/quicksort_top.sv ====
// Banked packet sorter top level joining loader, sorter, emitter and bank store
`timescale 1ns/10ps

module quicksort_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              unsorted_vld,
  input  logic              unsorted_sop,
  input  logic              unsorted_eop,
  input  qs_cfg_pkg::word_t unsorted_dat,
  output logic              unsorted_rdy,
  output logic              sorted_vld,
  output logic              sorted_sop,
  output logic              sorted_eop,
  output qs_cfg_pkg::word_t sorted_dat,
  output logic              busy
);
  import qs_cfg_pkg::*;
  import qs_ctrl_pkg::*;

  bank_state_t [bank_n-1:0] bank_status;
  word_t       [bank_n-1:0] rd_data;
  mem_req_t                 load_req;
  mem_req_t                 sort_req;
  mem_req_t                 emit_req;
  bank_update_t             load_upd;
  bank_update_t             sort_upd;
  bank_update_t             emit_upd;

  // Start strobe is not needed by the loader
  // a packet starts with the first word taken into an idle bank
  packet_loader u_loader (
    .clk          (clk),
    .rst          (rst),
    .unsorted_vld (unsorted_vld),
    .unsorted_eop (unsorted_eop),
    .unsorted_dat (unsorted_dat),
    .bank_status  (bank_status),
    .unsorted_rdy (unsorted_rdy),
    .mem_req      (load_req),
    .update       (load_upd)
  );

  partition_engine u_engine (
    .clk         (clk),
    .rst         (rst),
    .bank_status (bank_status),
    .rd_data     (rd_data),
    .mem_req     (sort_req),
    .update      (sort_upd)
  );

  packet_emitter u_emitter (
    .clk         (clk),
    .rst         (rst),
    .bank_status (bank_status),
    .rd_data     (rd_data),
    .mem_req     (emit_req),
    .update      (emit_upd),
    .sorted_vld  (sorted_vld),
    .sorted_sop  (sorted_sop),
    .sorted_eop  (sorted_eop),
    .sorted_dat  (sorted_dat)
  );

  bank_store u_store (
    .clk         (clk),
    .rst         (rst),
    .load_req    (load_req),
    .sort_req    (sort_req),
    .emit_req    (emit_req),
    .load_upd    (load_upd),
    .sort_upd    (sort_upd),
    .emit_upd    (emit_upd),
    .bank_status (bank_status),
    .rd_data     (rd_data),
    .busy        (busy)
  );

endmodule

// ==== verification/tb_quicksort.sv ====
// Packet sorter testbench that checks random packets against a sorting model
`timescale 1ns/10ps

module tb_quicksort;
  import qs_cfg_pkg::*;

  localparam int rand_pkts   = 40;
  localparam int burst_pkts  = 20;
  localparam int max_gap     = 8;
  localparam int total_pkts  = 2 + rand_pkts + burst_pkts;
  // Worst case quicksort on 16 words takes about five cycles per compared word per level
  localparam int sort_bound  = 5 * entry_n * entry_n;
  localparam int pkt_bound   = sort_bound + 4 * entry_n + max_gap;
  localparam int cycle_limit = total_pkts * pkt_bound + 200;
  // Cycles that busy may lag the last output word
  localparam int busy_lag    = 4;

  logic  clk;
  logic  rst;
  logic  unsorted_vld;
  logic  unsorted_sop;
  logic  unsorted_eop;
  word_t unsorted_dat;
  logic  unsorted_rdy;
  logic  sorted_vld;
  logic  sorted_sop;
  logic  sorted_eop;
  word_t sorted_dat;
  logic  busy;

  word_t       pkt_buf [entry_n];
  word_t       exp_q [$];
  int          exp_len_q [$];
  int          tx_count;
  int          rx_count;
  int          out_pos;
  int          error_count;
  int          tests_run;
  int          tests_failed;
  int          cycle_count;
  logic        rdy_prev;
  logic        frame_seen;

  quicksort_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .unsorted_vld (unsorted_vld),
    .unsorted_sop (unsorted_sop),
    .unsorted_eop (unsorted_eop),
    .unsorted_dat (unsorted_dat),
    .unsorted_rdy (unsorted_rdy),
    .sorted_vld   (sorted_vld),
    .sorted_sop   (sorted_sop),
    .sorted_eop   (sorted_eop),
    .sorted_dat   (sorted_dat),
    .busy         (busy)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got %0h expected %0h at cycle %0d", name, got, exp, cycle_count);
      error_count++;
    end
  endtask

  // Run length guard
  always @(posedge clk) begin
    cycle_count++;
    // Word accepted at this edge that opens or closes a packet
    frame_seen = unsorted_vld && (unsorted_sop || unsorted_eop);
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: no finish after %0d cycles, sorter or drain stalled", cycle_limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Ready may only drop right after a packet's first or last word was taken
  always @(negedge clk) begin
    if (!rst && rdy_prev && !unsorted_rdy && !frame_seen) begin
      $display("Ready dropped in the middle of a packet at cycle %0d", cycle_count);
      error_count++;
    end
    rdy_prev = unsorted_rdy;
  end

  // Output side compared word by word with the sorted copy
  always @(negedge clk) begin
    if (!rst && sorted_vld) begin
      if (exp_q.size() == 0) begin
        $display("Output word %0h arrived with no packet pending", sorted_dat);
        error_count++;
      end else begin
        check_value("sorted_dat", sorted_dat, exp_q.pop_front());
        check_value("sorted_sop", sorted_sop, out_pos == 0);
        check_value("sorted_eop", sorted_eop, out_pos == exp_len_q[0] - 1);
        if (out_pos == exp_len_q[0] - 1) begin
          void'(exp_len_q.pop_front());
          out_pos = 0;
          rx_count++;
        end else begin
          out_pos++;
        end
      end
    end
  end

  // Sorted copy goes into the model before the words go out as ready allows
  task automatic send_packet(input int len);
    word_t tmp [entry_n];
    word_t key;
    int    p;
    for (int k = 0; k < len; k++) begin
      tmp[k] = pkt_buf[k];
    end
    // Ascending insertion sort
    for (int k = 1; k < len; k++) begin
      key = tmp[k];
      p   = k - 1;
      while (p >= 0 && tmp[p] > key) begin
        tmp[p + 1] = tmp[p];
        p--;
      end
      tmp[p + 1] = key;
    end
    for (int k = 0; k < len; k++) begin
      exp_q.push_back(tmp[k]);
    end
    exp_len_q.push_back(len);
    tx_count++;
    while (!unsorted_rdy) @(negedge clk);
    for (int k = 0; k < len; k++) begin
      unsorted_vld = 1'b1;
      unsorted_sop = (k == 0);
      unsorted_eop = (k == len - 1);
      unsorted_dat = pkt_buf[k];
      @(negedge clk);
    end
    unsorted_vld = 1'b0;
    unsorted_sop = 1'b0;
    unsorted_eop = 1'b0;
  endtask

  task automatic random_packet(output int len);
    logic dup_mode;
    len      = $urandom_range(entry_n, 1);
    dup_mode = $urandom_range(1, 0);
    // Small values give plenty of duplicates
    for (int k = 0; k < len; k++) begin
      pkt_buf[k] = dup_mode ? word_t'($urandom_range(7, 0)) : word_t'($urandom);
    end
  endtask

  // Busy must fall within a few cycles of the last expected word
  task automatic wait_drain;
    int waited;
    waited = 0;
    while (rx_count < tx_count) @(negedge clk);
    while (busy && waited < busy_lag) begin
      @(negedge clk);
      waited++;
    end
    if (busy) begin
      $display("busy still high %0d cycles after the last packet drained", waited);
      error_count++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", num, name, error_count - errs_before);
    end
  endtask

  initial begin
    int errs;
    int len;
    clk          = 1'b0;
    rst          = 1'b1;
    unsorted_vld = 1'b0;
    unsorted_sop = 1'b0;
    unsorted_eop = 1'b0;
    unsorted_dat = '0;
    tx_count     = 0;
    rx_count     = 0;
    out_pos      = 0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycle_count  = 0;
    rdy_prev     = 1'b1;
    frame_seen   = 1'b0;
    void'($urandom(71164));
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    errs = error_count;
    @(negedge clk);
    check_value("busy", busy, 0);
    check_value("sorted_vld", sorted_vld, 0);
    check_value("unsorted_rdy", unsorted_rdy, 1);
    report_test(1, "reset state", errs);

    errs       = error_count;
    pkt_buf[0] = 16'hbeef;
    send_packet(1);
    wait_drain();
    report_test(2, "single word", errs);

    // Descending pairs of equal words
    errs = error_count;
    for (int k = 0; k < entry_n; k++) begin
      pkt_buf[k] = word_t'(16'h0800 - (k >> 1) * 16'h0100);
    end
    send_packet(entry_n);
    wait_drain();
    report_test(3, "descending full bank", errs);

    errs = error_count;
    for (int n = 0; n < rand_pkts; n++) begin
      random_packet(len);
      send_packet(len);
      repeat ($urandom_range(max_gap, 0)) @(negedge clk);
    end
    wait_drain();
    report_test(4, "random packets", errs);

    // Ready alone paces the source here
    errs = error_count;
    for (int n = 0; n < burst_pkts; n++) begin
      random_packet(len);
      send_packet(len);
    end
    wait_drain();
    report_test(5, "back to back", errs);

    errs = error_count;
    repeat (20) @(negedge clk);
    check_value("busy", busy, 0);
    check_value("unsorted_rdy", unsorted_rdy, 1);
    report_test(6, "idle after drain", errs);

    $display("tests %0d, failed %0d, errors %0d, packets %0d/%0d",
             tests_run, tests_failed, error_count, rx_count, tx_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
logic/qs_cfg_pkg.sv
logic/qs_ctrl_pkg.sv
logic/packet_loader.sv
logic/partition_engine.sv
logic/packet_emitter.sv
logic/bank_store.sv
logic/quicksort_top.sv
verification/tb_quicksort.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 -Wno-fatal
TOP       := tb_quicksort
FILELIST  := sim.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard logic/*.sv verification/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
